//--- Bender.yml
package:
  name: beam_sort

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/beam_pkg.sv
      - src/beam_capture.sv
      - src/beam_rank.sv
      - src/beam_select.sv
      - src/beam_store.sv
      - src/beam_sort_top.sv
      - target: test
        files:
          - tests/beam_sort_checker.sv
          - tests/tb_beam_sort.sv

//--- include/beam_config.svh
// Beam sort configuration

`ifndef BEAM_CONFIG_SVH
`define BEAM_CONFIG_SVH

// Beams per input vector
`define BEAM_COUNT  16

// Bit width of one power value
`define POWER_WIDTH 16

// Elements scored per cycle, must divide BEAM_COUNT
`define LANES       4

// Ranked beams kept per slot
`define TOP_COUNT   4

// Number of RBG slots
`define RBG_DEPTH   8

`endif

//--- project.f
+incdir+include
src/beam_pkg.sv
src/beam_capture.sv
src/beam_rank.sv
src/beam_select.sv
src/beam_store.sv
src/beam_sort_top.sv
tests/beam_sort_checker.sv
tests/tb_beam_sort.sv

//--- src/beam_capture.sv
// Beam vector input capture

`timescale 1ns/1ps

module beam_capture (
    input  logic               i_clk,
    input  logic               i_reset,
    // Four-phase request side
    input  logic               i_in_req,
    input  beam_pkg::beam_vec_t i_in_data,
    output logic               o_in_ack,
    // Towards the ranker
    input  logic               i_rank_idle,
    output logic               o_start,
    output beam_pkg::beam_vec_t o_vec
);

    logic full;
    logic take;
    logic release_vec;

    // New request only while the buffer is free and the last one is closed
    assign take        = i_in_req && !o_in_ack && !full;
    assign release_vec = full && i_rank_idle;

    // ----------------------------------------
    // Handshake phase and buffer state
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            full     <= 1'b0;
            o_in_ack <= 1'b0;
            o_start  <= 1'b0;
        end else begin
            o_start <= release_vec;
            if (release_vec) begin
                full <= 1'b0;
            end else if (take) begin
                full <= 1'b1;
            end
            // Ack follows req, falls one cycle after req drops
            if (take) begin
                o_in_ack <= 1'b1;
            end else if (o_in_ack && !i_in_req) begin
                o_in_ack <= 1'b0;
            end
        end
    end

    // Single request buffer
    always_ff @(posedge i_clk) begin
        if (take) begin
            o_vec <= i_in_data;
        end
    end

endmodule

//--- src/beam_pkg.sv
// Beam sort shared types

`include "beam_config.svh"

package beam_pkg;

    // ----------------------------------------
    // Scalar types
    // ----------------------------------------
    typedef logic [`POWER_WIDTH-1:0]        power_t;
    typedef logic [$clog2(`BEAM_COUNT)-1:0] beam_idx_t;
    typedef logic [$clog2(`BEAM_COUNT)-1:0] score_t;
    typedef logic [$clog2(`RBG_DEPTH)-1:0]  slot_t;

    // ----------------------------------------
    // Bundles between the stages
    // ----------------------------------------

    // One input request, powers plus target slot
    typedef struct packed {
        power_t [`BEAM_COUNT-1:0] power;
        slot_t                    slot;
    } beam_vec_t;

    // Request with one score per element
    typedef struct packed {
        beam_vec_t              vec;
        score_t [`BEAM_COUNT-1:0] score;
    } ranked_vec_t;

    // Strongest beams, entry 0 is the highest priority
    typedef struct packed {
        power_t    [`TOP_COUNT-1:0] power;
        beam_idx_t [`TOP_COUNT-1:0] idx;
    } top_entry_t;

    // Scoring engine states
    typedef enum logic [1:0] {
        IDLE,
        SCORE,
        EMIT
    } rank_state_t;

endpackage

//--- src/beam_rank.sv
// Lane-parallel beam scoring engine

`timescale 1ns/1ps
`include "beam_config.svh"

module beam_rank (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_start,
    input  beam_pkg::beam_vec_t   i_vec,
    output logic                 o_idle,
    output logic                 o_valid,
    output beam_pkg::ranked_vec_t o_ranked
);

    import beam_pkg::*;

    localparam int GROUPS  = `BEAM_COUNT / `LANES;
    localparam int GROUP_W = (GROUPS > 1) ? $clog2(GROUPS) : 1;

    rank_state_t          state;
    logic [GROUP_W-1:0]   group;
    score_t [`LANES-1:0]  lane_score;

    // ----------------------------------------
    // Control FSM
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= IDLE;
            group <= '0;
        end else begin
            case (state)
                IDLE: begin
                    group <= '0;
                    if (i_start) begin
                        state <= SCORE;
                    end
                end
                SCORE: begin
                    group <= group + 1'b1;
                    if (group == GROUP_W'(GROUPS - 1)) begin
                        state <= EMIT;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign o_idle  = (state == IDLE);
    assign o_valid = (state == EMIT);

    // ----------------------------------------
    // Comparator rows, one element per lane
    // ----------------------------------------
    always_comb begin
        int elem;
        for (int l = 0; l < `LANES; l++) begin
            elem          = int'(group) * `LANES + l;
            lane_score[l] = '0;
            for (int j = 0; j < `BEAM_COUNT; j++) begin
                // Larger value anywhere, or equal value at a lower index
                if (o_ranked.vec.power[j] > o_ranked.vec.power[elem]) begin
                    lane_score[l] = lane_score[l] + 1'b1;
                end else if (j < elem &&
                             o_ranked.vec.power[j] == o_ranked.vec.power[elem]) begin
                    lane_score[l] = lane_score[l] + 1'b1;
                end
            end
        end
    end

    // Vector latch and score array
    always_ff @(posedge i_clk) begin
        if (state == IDLE && i_start) begin
            o_ranked.vec <= i_vec;
        end
        if (state == SCORE) begin
            for (int l = 0; l < `LANES; l++) begin
                o_ranked.score[int'(group) * `LANES + l] <= lane_score[l];
            end
        end
    end

endmodule

//--- src/beam_select.sv
// Top beam selection by score

`timescale 1ns/1ps
`include "beam_config.svh"

module beam_select (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_valid,
    input  beam_pkg::ranked_vec_t i_ranked,
    output logic                 o_wr_en,
    output beam_pkg::slot_t       o_wr_slot,
    output beam_pkg::top_entry_t  o_wr_entry
);

    import beam_pkg::*;

    localparam int TOP_W = (`TOP_COUNT > 1) ? $clog2(`TOP_COUNT) : 1;

    top_entry_t next_entry;

    // Scatter by score, only the first TOP_COUNT positions are kept
    always_comb begin
        next_entry = '0;
        for (int i = 0; i < `BEAM_COUNT; i++) begin
            if (i_ranked.score[i] < score_t'(`TOP_COUNT)) begin
                next_entry.power[i_ranked.score[i][TOP_W-1:0]] = i_ranked.vec.power[i];
                next_entry.idx[i_ranked.score[i][TOP_W-1:0]]   = beam_idx_t'(i);
            end
        end
    end

    // Write strobe
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wr_en <= 1'b0;
        end else begin
            o_wr_en <= i_valid;
        end
    end

    // Entry and slot for the store
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_wr_slot  <= i_ranked.vec.slot;
            o_wr_entry <= next_entry;
        end
    end

endmodule

//--- src/beam_sort_top.sv
// Beam sort top level

`timescale 1ns/1ps

module beam_sort_top (
    input  logic                i_clk,
    input  logic                i_reset,
    // Vector input
    input  logic                i_in_req,
    input  beam_pkg::beam_vec_t  i_in_data,
    output logic                o_in_ack,
    // Slot readout
    input  logic                i_rd_req,
    input  beam_pkg::slot_t      i_rd_slot,
    output logic                o_rd_ack,
    output beam_pkg::top_entry_t o_rd_data
);

    import beam_pkg::*;

    logic        cap_start;
    beam_vec_t   cap_vec;
    logic        rank_idle;
    logic        rank_valid;
    ranked_vec_t ranked;
    logic        wr_en;
    slot_t       wr_slot;
    top_entry_t  wr_entry;

    beam_capture u_capture (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_in_req    (i_in_req),
        .i_in_data   (i_in_data),
        .o_in_ack    (o_in_ack),
        .i_rank_idle (rank_idle),
        .o_start     (cap_start),
        .o_vec       (cap_vec)
    );

    beam_rank u_rank (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_start  (cap_start),
        .i_vec    (cap_vec),
        .o_idle   (rank_idle),
        .o_valid  (rank_valid),
        .o_ranked (ranked)
    );

    beam_select u_select (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_valid    (rank_valid),
        .i_ranked   (ranked),
        .o_wr_en    (wr_en),
        .o_wr_slot  (wr_slot),
        .o_wr_entry (wr_entry)
    );

    beam_store u_store (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_wr_en    (wr_en),
        .i_wr_slot  (wr_slot),
        .i_wr_entry (wr_entry),
        .i_rd_req   (i_rd_req),
        .i_rd_slot  (i_rd_slot),
        .o_rd_ack   (o_rd_ack),
        .o_rd_data  (o_rd_data)
    );

endmodule

//--- src/beam_store.sv
// RBG slot memory with handshake readout

`timescale 1ns/1ps
`include "beam_config.svh"

module beam_store (
    input  logic                i_clk,
    input  logic                i_reset,
    // Write port from the selector
    input  logic                i_wr_en,
    input  beam_pkg::slot_t      i_wr_slot,
    input  beam_pkg::top_entry_t i_wr_entry,
    // Four-phase read port
    input  logic                i_rd_req,
    input  beam_pkg::slot_t      i_rd_slot,
    output logic                o_rd_ack,
    output beam_pkg::top_entry_t o_rd_data
);

    import beam_pkg::*;

    top_entry_t mem [`RBG_DEPTH];
    logic       rd_pend;

    // ----------------------------------------
    // Slot array
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int s = 0; s < `RBG_DEPTH; s++) begin
                mem[s] <= '0;
            end
        end else if (i_wr_en) begin
            mem[i_wr_slot] <= i_wr_entry;
        end
    end

    // ----------------------------------------
    // Read phase sequence
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rd_pend  <= 1'b0;
            o_rd_ack <= 1'b0;
        end else if (rd_pend) begin
            // Data registered this cycle, ack goes up with it
            rd_pend  <= 1'b0;
            o_rd_ack <= 1'b1;
        end else if (o_rd_ack) begin
            if (!i_rd_req) begin
                o_rd_ack <= 1'b0;
            end
        end else if (i_rd_req) begin
            rd_pend <= 1'b1;
        end
    end

    // Held until the next read
    always_ff @(posedge i_clk) begin
        if (rd_pend) begin
            o_rd_data <= mem[i_rd_slot];
        end
    end

endmodule

//--- tests/beam_sort_checker.sv
// Four-phase handshake checker

`timescale 1ns/1ps

module beam_sort_checker #(
    parameter int DATA_W = 1
) (
    input logic              i_clk,
    input logic              i_reset,
    input logic              i_req,
    input logic              i_ack,
    input logic [DATA_W-1:0] i_data
);

    int fail_count = 0;

    // Ack only answers a request
    ack_needs_req: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_ack) |-> $past(i_req))
    else begin
        $error("ack rose without a request");
        fail_count++;
    end

    // Request data held until acknowledged
    data_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_req && !i_ack && $past(i_req && !i_ack)) |-> $stable(i_data))
    else begin
        $error("request data changed before ack");
        fail_count++;
    end

    ack_release: assert property (@(posedge i_clk) disable iff (i_reset)
        $fell(i_req) |-> ##[0:2] !i_ack)
    else begin
        $error("ack stayed high after the request fell");
        fail_count++;
    end

endmodule

bind beam_capture beam_sort_checker #(
    .DATA_W ($bits(beam_pkg::beam_vec_t))
) u_handshake_checker (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_req   (i_in_req),
    .i_ack   (o_in_ack),
    .i_data  (i_in_data)
);

bind beam_store beam_sort_checker #(
    .DATA_W ($bits(beam_pkg::slot_t))
) u_handshake_checker (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_req   (i_rd_req),
    .i_ack   (o_rd_ack),
    .i_data  (i_rd_slot)
);

//--- tests/beam_stimulus.txt
// slot, 16 powers p0..p15, expected top indices i0..i3, expected top powers q0..q3
// Entry 0 is the strongest beam, equal powers keep the lower index first
0 100 101 102 103 104 105 106 107 108 109 10a 10b 10c 10d 10e 10f f e d c 10f 10e 10d 10c
1 2f0 2e0 2d0 2c0 2b0 2a0 290 280 270 260 250 240 230 220 210 200 0 1 2 3 2f0 2e0 2d0 2c0
2 055 055 055 055 055 055 055 055 055 055 055 055 055 055 055 055 0 1 2 3 055 055 055 055
3 3a1 012 7ff 0c4 5e0 233 001 6b2 0ff 444 7fe 123 00a 555 321 6b3 2 a f 7 7ff 7fe 6b3 6b2
4 090 040 070 090 070 020 070 010 000 030 070 050 060 010 020 005 0 3 2 4 090 090 070 070
5 000 000 000 000 000 000 000 000 000 001 000 000 000 000 000 fff f 9 0 1 fff 001 000 000
6 111 222 111 333 222 111 333 444 000 444 111 222 333 000 444 111 7 9 e 3 444 444 444 333
7 500 4ff 501 4fe 502 4fd 503 4fc 504 4fb 505 4fa 506 4f9 507 4f8 e c a 8 507 506 505 504
0 0aa 0aa 0aa 0aa 0ab 0aa 0aa 0aa 0aa 0aa 0aa 0ab 0aa 0aa 0aa 0aa 4 b 0 1 0ab 0ab 0aa 0aa
3 ffe fff 000 fff ffe 001 fff 002 fff 003 004 005 006 007 008 009 1 3 6 8 fff fff fff fff

//--- tests/tb_beam_sort.sv
// Beam sort testbench

`timescale 1ns/1ps
`include "beam_config.svh"

module tb_beam_sort;

    import beam_pkg::*;

    localparam int FILE_CASES       = 10;
    localparam int CASE_WORDS       = 1 + `BEAM_COUNT + 2 * `TOP_COUNT;
    localparam int RANDOM_CASES     = 12;
    localparam int BURST_CASES      = `RBG_DEPTH;
    // Cycles from ack to a readable slot through capture, rank, select and store
    localparam int PIPE_CYCLES      = `BEAM_COUNT / `LANES + 5;
    localparam int DRAIN_CYCLES     = 2 * PIPE_CYCLES;
    localparam int HANDSHAKE_CYCLES = 8;
    localparam int CASE_CYCLES      = 2 * HANDSHAKE_CYCLES + PIPE_CYCLES;
    localparam int SWEEP_CYCLES     = `RBG_DEPTH * HANDSHAKE_CYCLES;
    localparam int WATCHDOG_CYCLES  = 2 * (20 + (FILE_CASES + RANDOM_CASES) * CASE_CYCLES
                                      + BURST_CASES * 2 * HANDSHAKE_CYCLES + DRAIN_CYCLES
                                      + 4 * SWEEP_CYCLES);

    logic       clk;
    logic       reset;
    logic       in_req;
    beam_vec_t  in_data;
    logic       in_ack;
    logic       rd_req;
    slot_t      rd_slot;
    logic       rd_ack;
    top_entry_t rd_data;

    logic [`POWER_WIDTH-1:0] stim_words [FILE_CASES * CASE_WORDS];
    top_entry_t              expected_slot [`RBG_DEPTH];
    integer                  seed;

    beam_sort_top i_beam_sort_top (
        .i_clk     (clk),
        .i_reset   (reset),
        .i_in_req  (in_req),
        .i_in_data (in_data),
        .o_in_ack  (in_ack),
        .i_rd_req  (rd_req),
        .i_rd_slot (rd_slot),
        .o_rd_ack  (rd_ack),
        .o_rd_data (rd_data)
    );

    always #5 clk = ~clk;

    // ----------------------------------------
    // Reporting and compare tasks
    // ----------------------------------------
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_entry(input string name, input top_entry_t actual,
                               input top_entry_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h",
                                     name, actual, expected));
        end
    endtask

    task automatic check_ack(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            report_failure($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h",
                                     name, actual, expected));
        end
    endtask

    // Assertion failures counted by both bound checkers
    function automatic int handshake_failures();
        return i_beam_sort_top.u_capture.u_handshake_checker.fail_count
             + i_beam_sort_top.u_store.u_handshake_checker.fail_count;
    endfunction

    // Repeated pick of the largest unused power with ties going to the lowest index
    function automatic top_entry_t top_model(input beam_vec_t vec);
        top_entry_t             result;
        logic [`BEAM_COUNT-1:0] used;
        int                     best;
        result = '0;
        used   = '0;
        for (int t = 0; t < `TOP_COUNT; t++) begin
            best = -1;
            for (int k = 0; k < `BEAM_COUNT; k++) begin
                if (!used[k] && (best < 0 || vec.power[k] > vec.power[best])) begin
                    best = k;
                end
            end
            used[best]      = 1'b1;
            result.power[t] = vec.power[best];
            result.idx[t]   = beam_idx_t'(best);
        end
        return result;
    endfunction

    task automatic load_case(input int c, output beam_vec_t vec, output top_entry_t exp);
        int base;
        base     = c * CASE_WORDS;
        vec.slot = slot_t'(stim_words[base]);
        for (int k = 0; k < `BEAM_COUNT; k++) begin
            vec.power[k] = stim_words[base + 1 + k];
        end
        for (int t = 0; t < `TOP_COUNT; t++) begin
            exp.idx[t]   = beam_idx_t'(stim_words[base + 1 + `BEAM_COUNT + t]);
            exp.power[t] = stim_words[base + 1 + `BEAM_COUNT + `TOP_COUNT + t];
        end
    endtask

    task automatic make_random_vec(input slot_t slot, input bit narrow,
                                   output beam_vec_t vec);
        logic [31:0] word;
        vec.slot = slot;
        for (int k = 0; k < `BEAM_COUNT; k++) begin
            word = $random(seed);
            // Narrow range forces ties
            vec.power[k] = narrow ? power_t'(word[2:0]) : word[`POWER_WIDTH-1:0];
        end
    endtask

    // ----------------------------------------
    // Handshake drivers
    // ----------------------------------------
    task automatic send_vec(input beam_vec_t vec, output int latency);
        latency = 0;
        @(posedge clk);
        in_data <= vec;
        in_req  <= 1'b1;
        @(negedge clk);
        check_ack("o_in_ack", in_ack, 1'b0);
        while (!in_ack) begin
            latency++;
            @(negedge clk);
        end
        @(posedge clk);
        in_req <= 1'b0;
        @(negedge clk);
        while (in_ack) begin
            @(negedge clk);
        end
    endtask

    task automatic read_slot(input slot_t slot, output top_entry_t data);
        @(posedge clk);
        rd_slot <= slot;
        rd_req  <= 1'b1;
        @(negedge clk);
        check_ack("o_rd_ack", rd_ack, 1'b0);
        while (!rd_ack) begin
            @(negedge clk);
        end
        data = rd_data;
        @(posedge clk);
        rd_req <= 1'b0;
        @(negedge clk);
        while (rd_ack) begin
            @(negedge clk);
        end
    endtask

    task automatic write_and_check(input beam_vec_t vec, input top_entry_t exp);
        int         latency;
        top_entry_t got;
        send_vec(vec, latency);
        repeat (PIPE_CYCLES) @(posedge clk);
        read_slot(vec.slot, got);
        check_entry($sformatf("o_rd_data slot %0d", vec.slot), got, exp);
        expected_slot[vec.slot] = exp;
    endtask

    task automatic verify_all_slots();
        top_entry_t got;
        for (int s = 0; s < `RBG_DEPTH; s++) begin
            read_slot(slot_t'(s), got);
            check_entry($sformatf("o_rd_data slot %0d", s), got, expected_slot[s]);
        end
    endtask

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure("Watchdog timeout, the test sequence did not finish in time");
    end

    // Handshake assertions stop the run as soon as one fires
    always @(negedge clk) begin
        if (handshake_failures() != 0) begin
            report_failure($sformatf("%0d handshake assertion failures in the bound checkers",
                                     handshake_failures()));
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        beam_vec_t  vec;
        top_entry_t exp;
        int         latency;
        bit         saw_delay;
        clk       = 1'b0;
        reset     = 1'b1;
        in_req    = 1'b0;
        in_data   = '0;
        rd_req    = 1'b0;
        rd_slot   = '0;
        seed      = 32'hafe7;
        saw_delay = 1'b0;
        for (int s = 0; s < `RBG_DEPTH; s++) begin
            expected_slot[s] = '0;
        end
        $readmemh("tests/beam_stimulus.txt", stim_words);
        if ($isunknown(stim_words[FILE_CASES * CASE_WORDS - 1])) begin
            report_failure("Stimulus file tests/beam_stimulus.txt is missing or too short");
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // Quiet handshakes and empty slots after reset
        repeat (4) begin
            @(negedge clk);
            check_ack("o_in_ack", in_ack, 1'b0);
            check_ack("o_rd_ack", rd_ack, 1'b0);
        end
        verify_all_slots();

        // File cases one at a time on an idle pipeline
        for (int c = 0; c < FILE_CASES; c++) begin
            load_case(c, vec, exp);
            check_entry($sformatf("model vs file case %0d", c), top_model(vec), exp);
            write_and_check(vec, exp);
        end
        verify_all_slots();

        // Back-to-back burst over all slots
        for (int b = 0; b < BURST_CASES; b++) begin
            make_random_vec(slot_t'(b), b[0], vec);
            expected_slot[b] = top_model(vec);
            send_vec(vec, latency);
            if (latency > 1) begin
                saw_delay = 1'b1;
            end
        end
        if (!saw_delay) begin
            report_failure("Back-pressure never delayed o_in_ack during the request burst");
        end
        repeat (DRAIN_CYCLES) @(posedge clk);
        verify_all_slots();

        // Random vectors to random slots
        for (int r = 0; r < RANDOM_CASES; r++) begin
            make_random_vec(slot_t'($random(seed)), r[0], vec);
            write_and_check(vec, top_model(vec));
        end
        verify_all_slots();

        if (handshake_failures() == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            report_failure($sformatf("%0d handshake assertion failures in the bound checkers",
                                     handshake_failures()));
        end
    end

endmodule
